//--- flist.f
hw/core_pkg.sv
hw/core_mmu_arbiter.sv
hw/mem_bus_decoder.sv
hw/mem_sram.sv
hw/mem_io_regs.sv
hw/core_mmu.sv
test/core_mmu_assert.sv
test/tb_core_mmu.sv

//--- hw/core_mmu.sv
`timescale 1ns/1ps

module core_mmu (
	input  logic          clk,
	input  logic          rst_n,

	input  logic          insn_start,
	input  core_pkg::ptr  insn_addr,
	output logic          insn_ready,
	output core_pkg::word insn_data_rd,

	input  logic          data_start,
	input  logic          data_write,
	input  core_pkg::ptr  data_addr,
	input  core_pkg::word data_data_wr,
	output logic          data_ready,
	output core_pkg::word data_data_rd
);

	// Shared bus behind the arbiter.
	logic bus_start;
	core_pkg::bus_req_t bus_req;
	logic bus_ready;
	core_pkg::word bus_data_rd;

	// Target side of the decoder.
	logic sram_start;
	logic io_start;
	core_pkg::bus_req_t tgt_req;
	logic sram_ready;
	core_pkg::word sram_data_rd;
	logic io_ready;
	core_pkg::word io_data_rd;

	core_mmu_arbiter u_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.bus_ready    (bus_ready),
		.bus_data_rd  (bus_data_rd),
		.insn_start   (insn_start),
		.insn_addr    (insn_addr),
		.data_start   (data_start),
		.data_write   (data_write),
		.data_addr    (data_addr),
		.data_data_wr (data_data_wr),
		.bus_start    (bus_start),
		.bus_req      (bus_req),
		.insn_ready   (insn_ready),
		.data_ready   (data_ready),
		.insn_data_rd (insn_data_rd),
		.data_data_rd (data_data_rd)
	);

	mem_bus_decoder u_decoder (
		.clk          (clk),
		.rst_n        (rst_n),
		.bus_start    (bus_start),
		.bus_req      (bus_req),
		.sram_ready   (sram_ready),
		.sram_data_rd (sram_data_rd),
		.io_ready     (io_ready),
		.io_data_rd   (io_data_rd),
		.sram_start   (sram_start),
		.io_start     (io_start),
		.tgt_req      (tgt_req),
		.bus_ready    (bus_ready),
		.bus_data_rd  (bus_data_rd)
	);

	mem_sram u_sram (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (sram_start),
		.req     (tgt_req),
		.ready   (sram_ready),
		.data_rd (sram_data_rd)
	);

	mem_io_regs u_io (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (io_start),
		.req     (tgt_req),
		.ready   (io_ready),
		.data_rd (io_data_rd)
	);

endmodule

//--- hw/core_mmu_arbiter.sv
`timescale 1ns/1ps

module core_mmu_arbiter (
	input  logic               clk,
	input  logic               rst_n,

	input  logic               bus_ready,
	input  core_pkg::word      bus_data_rd,

	input  logic               insn_start,
	input  core_pkg::ptr       insn_addr,

	input  logic               data_start,
	input  logic               data_write,
	input  core_pkg::ptr       data_addr,
	input  core_pkg::word      data_data_wr,

	output logic               bus_start,
	output core_pkg::bus_req_t bus_req,
	output logic               insn_ready,
	output logic               data_ready,
	output core_pkg::word      insn_data_rd,
	output core_pkg::word      data_data_rd
);

	typedef enum logic {
		INSN,
		DATA
	} master_t;

	master_t master;
	master_t next_master;

	logic active; // Transaction on the bus.
	logic hold_start;
	core_pkg::bus_req_t hold_req;
	core_pkg::bus_req_t insn_req;
	core_pkg::bus_req_t data_req;
	logic transition;
	logic hold_issue;
	logic hold_free;

	assign insn_req = '{addr: insn_addr, write: 1'b0, data_wr: '0};
	assign data_req = '{addr: data_addr, write: data_write, data_wr: data_data_wr};

	// Master may only change when the bus is free or turning.
	always_comb begin
		next_master = master;
		if (bus_ready || !active) begin
			unique case (master)
				DATA: next_master = data_start ? DATA : INSN;
				INSN: next_master = (data_start || hold_start) ? DATA : INSN;
			endcase
		end
	end

	assign transition = master != next_master;
	assign hold_issue = transition && hold_start; // Held side gets the bus.
	assign hold_free = transition || !hold_start;

	// Ready belongs to whoever owns the current transaction.
	assign insn_ready = (master == INSN) && bus_ready;
	assign data_ready = (master == DATA) && bus_ready;
	assign insn_data_rd = bus_data_rd;
	assign data_data_rd = bus_data_rd;

	always_comb begin
		if (hold_issue) begin
			bus_start = 1'b1;
			bus_req = hold_req;
		end else if (next_master == DATA) begin
			bus_start = data_start;
			bus_req = data_req;
		end else begin
			bus_start = insn_start;
			bus_req = insn_req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			master <= INSN;
			active <= 1'b0;
			hold_start <= 1'b0;
		end else begin
			master <= next_master;
			active <= bus_start || (active && !bus_ready);
			// The side that is not master next cycle waits here.
			if (hold_free)
				hold_start <= (next_master == DATA) ? insn_start : data_start;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_free)
			hold_req <= (next_master == DATA) ? insn_req : data_req;
	end

endmodule

//--- hw/core_pkg.sv
package core_pkg;

	// Bus data word.
	typedef logic [31:0] word;

	// Word address, byte address without its two low bits.
	typedef logic [29:0] ptr;

	// One bus transaction as issued by the arbiter.
	typedef struct packed {
		ptr   addr;
		logic write;
		word  data_wr;
	} bus_req_t;

	// Address map. Everything from IO_BASE up is the register block.
	localparam ptr IO_BASE = 30'h0400_0000; // Byte address 0x1000_0000.

	// SRAM geometry.
	localparam int SRAM_WORDS = 1024;
	localparam int SRAM_AW = $clog2(SRAM_WORDS);

	// Wait states before the SRAM access.
	localparam int SRAM_WAIT = 2;
	localparam int WAIT_W = $clog2(SRAM_WAIT + 1);
	localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(SRAM_WAIT - 1);

	// Register offsets inside the I/O region.
	localparam ptr IO_SCRATCH = 30'd0;
	localparam ptr IO_WCOUNT = 30'd1;

endpackage

//--- hw/mem_bus_decoder.sv
`timescale 1ns/1ps

module mem_bus_decoder (
	input  logic               clk,
	input  logic               rst_n,

	input  logic               bus_start,
	input  core_pkg::bus_req_t bus_req,

	input  logic               sram_ready,
	input  core_pkg::word      sram_data_rd,
	input  logic               io_ready,
	input  core_pkg::word      io_data_rd,

	output logic               sram_start,
	output logic               io_start,
	output core_pkg::bus_req_t tgt_req,
	output logic               bus_ready,
	output core_pkg::word      bus_data_rd
);

	logic is_io;
	logic pending; // Transaction outstanding at a target.
	logic sel_io;  // Owner of that transaction.

	assign is_io = bus_req.addr >= core_pkg::IO_BASE;

	// Start goes to exactly one target.
	assign sram_start = bus_start && !is_io;
	assign io_start = bus_start && is_io;
	assign tgt_req = bus_req;

	// Response from the recorded owner only.
	assign bus_ready = pending && (sel_io ? io_ready : sram_ready);
	assign bus_data_rd = sel_io ? io_data_rd : sram_data_rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			sel_io <= 1'b0;
		end else if (bus_start) begin
			// A start in a ready cycle replaces the finished owner.
			pending <= 1'b1;
			sel_io <= is_io;
		end else if (bus_ready) begin
			pending <= 1'b0;
		end
	end

endmodule

//--- hw/mem_io_regs.sv
`timescale 1ns/1ps

module mem_io_regs (
	input  logic               clk,
	input  logic               rst_n,

	input  logic               start,
	input  core_pkg::bus_req_t req,

	output logic               ready,
	output core_pkg::word      data_rd
);

	core_pkg::ptr offset;
	core_pkg::word scratch;
	core_pkg::word wcount; // Writes into the region since reset.

	assign offset = req.addr - core_pkg::IO_BASE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready <= 1'b0;
			scratch <= '0;
			wcount <= '0;
		end else begin
			ready <= start;
			if (start && req.write) begin
				wcount <= wcount + 1'b1;
				// Counter offset takes the write but keeps no data.
				if (offset == core_pkg::IO_SCRATCH)
					scratch <= req.data_wr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			case (offset)
				core_pkg::IO_SCRATCH: data_rd <= scratch;
				core_pkg::IO_WCOUNT:  data_rd <= wcount;
				default:              data_rd <= '0;
			endcase
		end
	end

endmodule

//--- hw/mem_sram.sv
`timescale 1ns/1ps

module mem_sram (
	input  logic               clk,
	input  logic               rst_n,

	input  logic               start,
	input  core_pkg::bus_req_t req,

	output logic               ready,
	output core_pkg::word      data_rd
);

	core_pkg::word mem [core_pkg::SRAM_WORDS];

	core_pkg::bus_req_t req_q;
	logic busy;
	logic [core_pkg::WAIT_W-1:0] wait_cnt;
	logic access; // Last wait cycle, array is touched at its edge.
	logic [core_pkg::SRAM_AW-1:0] index;

	// Upper address bits below IO_BASE alias.
	assign index = req_q.addr[core_pkg::SRAM_AW-1:0];
	assign access = busy && (wait_cnt == core_pkg::WAIT_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			wait_cnt <= '0;
			ready <= 1'b0;
		end else begin
			ready <= access; // One cycle pulse.
			if (start) begin
				busy <= 1'b1;
				wait_cnt <= '0;
			end else if (access) begin
				busy <= 1'b0;
			end else if (busy) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			req_q <= req;

		if (access) begin
			if (req_q.write)
				mem[index] <= req_q.data_wr;
			data_rd <= mem[index]; // Old contents on a write.
		end
	end

endmodule

//--- test/core_mmu_assert.sv
`timescale 1ns/1ps

module core_mmu_assert (
	input logic clk,
	input logic rst_n,
	input logic bus_start,
	input logic bus_ready,
	input logic active,
	input logic insn_ready,
	input logic data_ready
);

	// Each ready belongs to one port and ends an outstanding transaction.
	ready_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		(insn_ready || data_ready) |-> (active && !(insn_ready && data_ready)))
		else $error("ready without an outstanding transaction or on both ports");

	// New start only on an idle or turning bus.
	start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
		bus_start |-> (!active || bus_ready))
		else $error("bus_start issued while a transaction is outstanding");

	ready_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!insn_ready && !data_ready))
		else $error("ready high in the first cycle after reset");

endmodule

bind core_mmu_arbiter core_mmu_assert u_arbiter_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.bus_start  (bus_start),
	.bus_ready  (bus_ready),
	.active     (active),
	.insn_ready (insn_ready),
	.data_ready (data_ready)
);

//--- test/tb_core_mmu.sv
`timescale 1ns/1ps

module tb_core_mmu;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 6;
	localparam int READY_LIMIT = 20;
	localparam int SRAM_LAT = core_pkg::SRAM_WAIT + 1;
	localparam int IO_LAT = 1;

	logic clk;
	logic rst_n;
	logic insn_start;
	core_pkg::ptr insn_addr;
	logic insn_ready;
	core_pkg::word insn_data_rd;
	logic data_start;
	logic data_write;
	core_pkg::ptr data_addr;
	core_pkg::word data_data_wr;
	logic data_ready;
	core_pkg::word data_data_rd;

	int cyc;
	int checks;
	int errors;
	int data_t0; // Cycle stamp of the last start per port.
	int insn_t0;
	int ref_wcount;
	core_pkg::word ref_mem [core_pkg::SRAM_WORDS];
	core_pkg::ptr written [$];

	core_mmu u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.insn_start   (insn_start),
		.insn_addr    (insn_addr),
		.insn_ready   (insn_ready),
		.insn_data_rd (insn_data_rd),
		.data_start   (data_start),
		.data_write   (data_write),
		.data_addr    (data_addr),
		.data_data_wr (data_data_wr),
		.data_ready   (data_ready),
		.data_data_rd (data_data_rd)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic check_word(input string name, input core_pkg::word exp,
			input core_pkg::word act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	function automatic logic [core_pkg::SRAM_AW-1:0] sram_index(input core_pkg::ptr a);
		return a[core_pkg::SRAM_AW-1:0];
	endfunction

	// Starts last one cycle.
	task automatic tick();
		@(negedge clk);
		insn_start = 1'b0;
		data_start = 1'b0;
	endtask

	task automatic issue_data(input logic write, input core_pkg::ptr addr,
			input core_pkg::word wdata);
		data_start = 1'b1;
		data_write = write;
		data_addr = addr;
		data_data_wr = wdata;
		data_t0 = cyc;
	endtask

	task automatic issue_fetch(input core_pkg::ptr addr);
		insn_start = 1'b1;
		insn_addr = addr;
		insn_t0 = cyc;
	endtask

	task automatic wait_ready(input logic on_data, input int t0, input int latency,
			output core_pkg::word rdata);
		logic hit;
		logic wrong;
		string port;
		int n;
		hit = 1'b0;
		wrong = 1'b0;
		n = 0;
		rdata = '0;
		port = on_data ? "data_ready" : "insn_ready";
		while (!hit && n < READY_LIMIT) begin
			tick();
			n++;
			if ((on_data ? insn_ready : data_ready) && !wrong) begin
				wrong = 1'b1;
				errors++;
				$display("ready came on the other port at %0t while waiting for %s",
					$time, port);
			end
			if (on_data ? data_ready : insn_ready) begin
				hit = 1'b1;
				rdata = on_data ? data_data_rd : insn_data_rd;
			end
		end
		if (!hit) begin
			errors++;
			$display("%s never came within %0d cycles at %0t", port, READY_LIMIT, $time);
		end else begin
			check_word({port, " latency"}, core_pkg::word'(latency), core_pkg::word'(cyc - t0));
		end
	endtask

	task automatic io_access(input logic write, input core_pkg::ptr addr,
			input core_pkg::word wdata, output core_pkg::word rdata);
		tick();
		issue_data(write, addr, wdata);
		wait_ready(1'b1, data_t0, IO_LAT, rdata);
		if (write)
			ref_wcount++; // Any write into the region counts.
	endtask

	task automatic apply_reset();
		int i;
		rst_n = 1'b0;
		insn_start = 1'b0;
		data_start = 1'b0;
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			check_flag("insn_ready", 1'b0, insn_ready);
			check_flag("data_ready", 1'b0, data_ready);
		end
		rst_n = 1'b1;
		ref_wcount = 0;
		@(negedge clk);
		check_flag("insn_ready", 1'b0, insn_ready);
		check_flag("data_ready", 1'b0, data_ready);
	endtask

	task automatic report_test(input string name, input int err0);
		$display("%s: %0d errors", name, errors - err0);
	endtask

	task automatic test_sram_write_read();
		int err0;
		int i;
		core_pkg::ptr a;
		core_pkg::word v;
		core_pkg::word rd;
		err0 = errors;
		for (i = 0; i < 8; i++) begin
			a = core_pkg::ptr'($urandom_range(core_pkg::IO_BASE - 1, 0));
			v = $urandom;
			tick();
			issue_data(1'b1, a, v);
			wait_ready(1'b1, data_t0, SRAM_LAT, rd);
			ref_mem[sram_index(a)] = v;
			written.push_back(a);
		end
		for (i = 0; i < written.size(); i++) begin
			a = written[i];
			tick();
			issue_data(1'b0, a, '0);
			wait_ready(1'b1, data_t0, SRAM_LAT, rd);
			check_word("data_data_rd", ref_mem[sram_index(a)], rd);
		end
		report_test("sram write/read", err0);
	endtask

	task automatic test_fetch_reads();
		int err0;
		int i;
		core_pkg::ptr a;
		core_pkg::word rd;
		err0 = errors;
		for (i = 0; i < written.size(); i++) begin
			a = written[i];
			tick();
			issue_fetch(a);
			wait_ready(1'b0, insn_t0, SRAM_LAT, rd); // Flags any data_ready.
			check_word("insn_data_rd", ref_mem[sram_index(a)], rd);
		end
		report_test("fetch reads", err0);
	endtask

	task automatic test_simultaneous();
		int err0;
		int i;
		core_pkg::ptr a;
		core_pkg::ptr b;
		core_pkg::word v;
		core_pkg::word rd;
		err0 = errors;
		for (i = 0; i < 2; i++) begin
			a = written[i];
			b = written[i + 2];
			v = $urandom;
			tick();
			if (i == 0)
				issue_data(1'b0, a, '0);
			else
				issue_data(1'b1, b, v); // Data goes first, fetch sees new word.
			issue_fetch(b);
			wait_ready(1'b1, data_t0, SRAM_LAT, rd);
			if (i == 0)
				check_word("data_data_rd", ref_mem[sram_index(a)], rd);
			else
				ref_mem[sram_index(b)] = v;
			wait_ready(1'b0, insn_t0, 2 * SRAM_LAT, rd);
			check_word("insn_data_rd", ref_mem[sram_index(b)], rd);
		end
		report_test("simultaneous starts", err0);
	endtask

	task automatic test_fetch_behind_data();
		int err0;
		int d;
		core_pkg::ptr a;
		core_pkg::ptr b;
		core_pkg::word rd;
		err0 = errors;
		for (d = 1; d < SRAM_LAT; d++) begin
			a = written[d];
			b = written[d + 3];
			tick();
			issue_data(1'b0, a, '0);
			repeat (d) tick();
			issue_fetch(b);
			wait_ready(1'b1, data_t0, SRAM_LAT, rd);
			check_word("data_data_rd", ref_mem[sram_index(a)], rd);
			// Held fetch goes out at the data ready.
			wait_ready(1'b0, insn_t0, 2 * SRAM_LAT - d, rd);
			check_word("insn_data_rd", ref_mem[sram_index(b)], rd);
		end
		report_test("fetch behind data", err0);
	endtask

	task automatic test_io_regs();
		int err0;
		core_pkg::ptr s;
		core_pkg::ptr w;
		core_pkg::word v;
		core_pkg::word rd;
		err0 = errors;
		s = core_pkg::IO_BASE + core_pkg::IO_SCRATCH;
		w = core_pkg::IO_BASE + core_pkg::IO_WCOUNT;
		v = $urandom;
		io_access(1'b1, s, v, rd);
		io_access(1'b0, s, '0, rd);
		check_word("scratch", v, rd);
		io_access(1'b1, w, ~v, rd); // Counted, not stored.
		io_access(1'b0, s, '0, rd);
		check_word("scratch", v, rd);
		io_access(1'b0, w, '0, rd);
		check_word("wcount", core_pkg::word'(ref_wcount), rd);
		io_access(1'b0, core_pkg::IO_BASE + 30'd2, '0, rd);
		check_word("unused io offset", '0, rd);
		report_test("io registers", err0);
	endtask

	task automatic test_reset_state();
		int err0;
		core_pkg::ptr a;
		core_pkg::word rd;
		err0 = errors;
		apply_reset();
		a = written[0];
		tick();
		issue_fetch(a);
		wait_ready(1'b0, insn_t0, SRAM_LAT, rd);
		check_word("insn_data_rd", ref_mem[sram_index(a)], rd);
		io_access(1'b0, core_pkg::IO_BASE + core_pkg::IO_WCOUNT, '0, rd);
		check_word("wcount", core_pkg::word'(ref_wcount), rd);
		report_test("reset state", err0);
	endtask

	initial begin
		void'($urandom(32'h37b));
		clk = 1'b0;
		rst_n = 1'b0;
		insn_start = 1'b0;
		insn_addr = '0;
		data_start = 1'b0;
		data_write = 1'b0;
		data_addr = '0;
		data_data_wr = '0;
		cyc = 0;
		checks = 0;
		errors = 0;
		ref_wcount = 0;
		apply_reset();
		test_sram_write_read();
		test_fetch_reads();
		test_simultaneous();
		test_fetch_behind_data();
		test_io_regs();
		test_reset_state();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run is stuck", NUM_TESTS * 200);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule
